//--- Bender.yml
package:
  name: rv64_core

sources:
  - hdl/riscv_isa_pkg.sv
  - hdl/core_pkg.sv
  - hdl/fetch_unit.sv
  - hdl/register_decode.sv
  - hdl/alu.sv
  - hdl/core_top.sv
  - target: test
    files:
      - bench/core_properties.sv
      - bench/core_tb.sv

//--- bench/core_properties.sv
module core_properties #(
  parameter int addr_width = 32
) (
  input logic                  clk,
  input logic                  reset,
  input logic                  wb_cyc,
  input logic                  wb_stb,
  input logic [addr_width-1:0] wb_adr,
  input logic                  wb_ack,
  input logic                  retire_valid,
  input logic                  halted
);
  int fail_count = 0;

  stb_within_cyc: assert property (@(posedge clk) disable iff (reset) wb_stb |-> wb_cyc)
    else begin
      $error("stb high without cyc");
      fail_count++;
    end

  // address holds until the slave acks
  adr_stable: assert property (@(posedge clk) disable iff (reset)
    wb_stb && !wb_ack |=> $stable(wb_adr))
    else begin
      $error("wb_adr changed during a pending request");
      fail_count++;
    end

  no_retire_after_halt: assert property (@(posedge clk) disable iff (reset)
    halted |=> !retire_valid)
    else begin
      $error("retire_valid high after halt");
      fail_count++;
    end

endmodule

bind fetch_unit core_properties #(
  .addr_width(bus_addr_width)
) bus_props0 (
  .clk(clk),
  .reset(reset),
  .wb_cyc(wb_cyc),
  .wb_stb(wb_stb),
  .wb_adr(wb_adr),
  .wb_ack(wb_ack),
  .retire_valid(1'b0),
  .halted(halted)
);

bind alu core_properties retire_props0 (
  .clk(clk),
  .reset(reset),
  .wb_cyc(1'b0),
  .wb_stb(1'b0),
  .wb_adr('0),
  .wb_ack(1'b0),
  .retire_valid(retire_valid),
  .halted(halted)
);

//--- bench/core_tb.sv
module core_tb;
  import core_pkg::*;
  import riscv_isa_pkg::*;

  localparam int bus_addr_width = 32;
  localparam int mem_words = 32;
  localparam logic [xlen-1:0] entry_pc = 64'h1000;
  // retired instructions over all runs, rounded up
  localparam int test_instrs = 80;
  // three wait states, the ack cycle and a discarded fetch after a redirect
  localparam int worst_cpi = 12;
  localparam int cycle_limit = test_instrs * 8 * worst_cpi + 400;

  typedef struct packed {
    logic [xlen-1:0] pc;
    logic [reg_idx_width-1:0] rd;
    logic [xlen-1:0] data;
  } trace_t;

  logic clk;
  logic reset;
  logic [xlen-1:0] entry;
  logic wb_ack;
  logic [instr_width-1:0] wb_dat_i;
  logic wb_cyc;
  logic wb_stb;
  logic [bus_addr_width-1:0] wb_adr;
  logic retire_valid;
  logic [xlen-1:0] retire_pc;
  logic [reg_idx_width-1:0] retire_rd;
  logic [xlen-1:0] retire_data;
  logic halted;

  logic [instr_width-1:0] mem [mem_words];
  int prog_len;
  logic use_waits;
  logic [15:0] lfsr_state;
  logic [1:0] wait_left;
  logic req_open;
  logic [bus_addr_width-1:0] word_offset;
  int cycle_count;
  int check_count;
  int error_count;
  int assert_fails;
  trace_t seen;
  trace_t exp_trace [$];
  trace_t got_trace [$];

  core_top #(
    .bus_addr_width(bus_addr_width)
  ) dut0 (
    .clk(clk),
    .reset(reset),
    .entry(entry),
    .wb_ack(wb_ack),
    .wb_dat_i(wb_dat_i),
    .wb_cyc(wb_cyc),
    .wb_stb(wb_stb),
    .wb_adr(wb_adr),
    .retire_valid(retire_valid),
    .retire_pc(retire_pc),
    .retire_rd(retire_rd),
    .retire_data(retire_data),
    .halted(halted)
  );

  initial clk = 1'b0;
  always #4 clk = ~clk;

  // taps 16, 14, 13, 11
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  function automatic logic [instr_width-1:0] r_type_word(input logic [6:0] f7, input int rs2,
                                                         input int rs1, input logic [2:0] f3,
                                                         input int rd);
    return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), opc_op};
  endfunction

  function automatic logic [instr_width-1:0] addi_word(input int rd, input int rs1,
                                                       input int imm);
    return {12'(imm), 5'(rs1), f3_add_sub, 5'(rd), opc_op_imm};
  endfunction

  function automatic logic [instr_width-1:0] lui_word(input int rd, input logic [19:0] upper);
    return {upper, 5'(rd), opc_lui};
  endfunction

  function automatic logic [instr_width-1:0] branch_word(input logic [2:0] f3, input int rs1,
                                                         input int rs2, input int offset);
    logic [12:0] o;
    o = 13'(offset);
    return {o[12], o[10:5], 5'(rs2), 5'(rs1), f3, o[4:1], o[11], opc_branch};
  endfunction

  function automatic logic [instr_width-1:0] jal_word(input int rd, input int offset);
    logic [20:0] o;
    o = 21'(offset);
    return {o[20], o[10:1], o[11], o[19:12], 5'(rd), opc_jal};
  endfunction

  function automatic logic [instr_width-1:0] ecall_word();
    return {{(instr_width-opcode_width){1'b0}}, opc_system};
  endfunction

  task automatic check_value(input string what, input logic [xlen-1:0] got,
                             input logic [xlen-1:0] exp);
    check_count++;
    assert (got === exp) else begin
      $display("error %0t: %s is %h, expected %h", $time, what, got, exp);
      error_count++;
    end
  endtask

  task automatic compare_trace(input string what, input trace_t got, input trace_t exp);
    check_value({what, " pc"}, got.pc, exp.pc);
    check_value({what, " rd"}, xlen'(got.rd), xlen'(exp.rd));
    check_value({what, " data"}, got.data, exp.data);
  endtask

  // wishbone slave, 0 to 3 wait states before ack, words past the program read as ecall
  always @(posedge clk) begin
    if (reset || wb_ack) begin
      wb_ack <= 1'b0;
      req_open = 1'b0;
    end else if (wb_stb) begin
      if (!req_open) begin
        req_open = 1'b1;
        wait_left = 2'd0;
        if (use_waits) begin
          lfsr_state = lfsr_step(lfsr_state);
          wait_left[1] = lfsr_state[0];
          lfsr_state = lfsr_step(lfsr_state);
          wait_left[0] = lfsr_state[0];
        end
      end
      if (wait_left == 2'd0) begin
        word_offset = (wb_adr - entry[bus_addr_width-1:0]) >> 2;
        wb_ack <= 1'b1;
        wb_dat_i <= (word_offset < prog_len) ? mem[word_offset] : ecall_word();
        req_open = 1'b0;
      end else begin
        wait_left = wait_left - 2'd1;
      end
    end
  end

  // retire monitor
  always @(posedge clk) begin
    if (!reset && retire_valid) begin
      seen.pc = retire_pc;
      seen.rd = retire_rd;
      seen.data = retire_data;
      assert (got_trace.size() < exp_trace.size()) else begin
        $display("an instruction at pc %h retired after the end of the program", retire_pc);
        error_count++;
      end
      if (got_trace.size() < exp_trace.size()) begin
        compare_trace("retire", seen, exp_trace[got_trace.size()]);
      end
      got_trace.push_back(seen);
    end
  end

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= cycle_limit) begin
      $display("timeout: the core did not finish the tests within %0d cycles", cycle_limit);
      $display("checks %0d, errors %0d", check_count, error_count + 1);
      $display("Regression failed");
      $finish;
    end
  end

  task automatic append_instr(input logic [instr_width-1:0] word);
    mem[prog_len] = word;
    prog_len++;
  endtask

  // ISA model of the program in mem, gives the expected retire stream
  task automatic build_expected();
    logic [xlen-1:0] regs [reg_count];
    logic [xlen-1:0] pc;
    logic [xlen-1:0] next_pc;
    logic [xlen-1:0] offset;
    logic [xlen-1:0] a;
    logic [xlen-1:0] b;
    logic [xlen-1:0] result;
    logic [instr_width-1:0] ins;
    logic [reg_idx_width-1:0] rd;
    logic [funct3_width-1:0] f3;
    logic writes;
    logic done;
    trace_t entry_item;
    foreach (regs[i]) begin
      regs[i] = '0;
    end
    exp_trace.delete();
    pc = entry;
    done = 1'b0;
    while (!done && exp_trace.size() < 200) begin
      offset = (pc - entry) >> 2;
      ins = (offset < prog_len) ? mem[offset] : ecall_word();
      rd = ins[rd_lsb +: reg_idx_width];
      f3 = ins[funct3_lsb +: funct3_width];
      a = regs[ins[rs1_lsb +: reg_idx_width]];
      b = regs[ins[rs2_lsb +: reg_idx_width]];
      next_pc = pc + 4;
      writes = 1'b1;
      result = '0;
      case (ins[opcode_lsb +: opcode_width])
        opc_op: begin
          case (f3)
            f3_add_sub: begin
              result = (ins[funct7_lsb +: funct7_width] == funct7_sub) ? a - b : a + b;
            end
            f3_and: result = a & b;
            f3_or: result = a | b;
            f3_xor: result = a ^ b;
            f3_slt: result = xlen'($signed(a) < $signed(b));
            default: result = '0;
          endcase
        end
        opc_op_imm: result = a + xlen'($signed(ins[31:20]));
        opc_lui: result = xlen'($signed({ins[31:12], 12'b0}));
        opc_branch: begin
          writes = 1'b0;
          if ((f3 == f3_beq && a == b) || (f3 == f3_bne && a != b)) begin
            next_pc = pc + xlen'($signed({ins[31], ins[7], ins[30:25], ins[11:8], 1'b0}));
          end
        end
        opc_jal: begin
          result = pc + 4;
          next_pc = pc + xlen'($signed({ins[31], ins[19:12], ins[20], ins[30:21], 1'b0}));
        end
        default: begin
          // ecall ends the program
          writes = 1'b0;
          done = 1'b1;
        end
      endcase
      entry_item.pc = pc;
      entry_item.rd = writes ? rd : '0;
      entry_item.data = writes ? result : '0;
      exp_trace.push_back(entry_item);
      if (writes && rd != 0) begin
        regs[rd] = result;
      end
      pc = next_pc;
    end
  endtask

  task automatic run_program(input logic waits);
    int settle;
    use_waits = waits;
    build_expected();
    got_trace.delete();
    @(posedge clk);
    reset <= 1'b1;
    repeat (3) @(posedge clk);
    reset <= 1'b0;
    @(negedge clk);
    assert (!wb_cyc && !wb_stb && !retire_valid && !halted) else begin
      $display("bus or retire outputs were active in the first cycle after reset");
      error_count++;
    end
    while (!halted) begin
      @(negedge clk);
    end
    // an open bus cycle may still finish after the halt
    settle = 0;
    while (wb_cyc && settle < 8) begin
      @(negedge clk);
      settle++;
    end
    repeat (10) begin
      @(negedge clk);
      assert (!wb_cyc) else begin
        $display("the core fetched again after it halted");
        error_count++;
      end
    end
    check_value("retire count", xlen'(got_trace.size()), xlen'(exp_trace.size()));
  endtask

  task automatic register_ops_test();
    prog_len = 0;
    append_instr(addi_word(1, 0, -5));
    append_instr(addi_word(2, 0, 7));
    append_instr(r_type_word(7'b0, 2, 1, f3_add_sub, 3));
    append_instr(r_type_word(funct7_sub, 2, 1, f3_add_sub, 4));
    append_instr(r_type_word(7'b0, 2, 1, f3_and, 5));
    append_instr(r_type_word(7'b0, 2, 1, f3_or, 6));
    append_instr(r_type_word(7'b0, 2, 1, f3_xor, 7));
    append_instr(r_type_word(7'b0, 2, 1, f3_slt, 8));
    append_instr(r_type_word(7'b0, 1, 2, f3_slt, 9));
    // both operands negative
    append_instr(r_type_word(7'b0, 1, 4, f3_slt, 10));
    append_instr(ecall_word());
    run_program(1'b1);
  endtask

  task automatic immediate_test();
    prog_len = 0;
    append_instr(addi_word(1, 0, -2048));
    append_instr(addi_word(2, 1, 2047));
    append_instr(lui_word(3, 20'h80000));
    append_instr(lui_word(4, 20'h12345));
    append_instr(addi_word(5, 3, -1));
    append_instr(addi_word(0, 0, 5));
    append_instr(r_type_word(7'b0, 2, 0, f3_add_sub, 6));
    append_instr(ecall_word());
    run_program(1'b1);
  endtask

  task automatic load_branch_program();
    prog_len = 0;
    append_instr(addi_word(1, 0, 3));
    append_instr(addi_word(2, 0, 3));
    append_instr(branch_word(f3_beq, 1, 2, 8));
    append_instr(addi_word(3, 0, 1));
    append_instr(branch_word(f3_bne, 1, 2, 8));
    append_instr(addi_word(4, 0, 2));
    append_instr(branch_word(f3_bne, 1, 0, 8));
    append_instr(addi_word(5, 0, 9));
    append_instr(branch_word(f3_beq, 1, 0, 8));
    append_instr(addi_word(6, 0, 3));
    // count down loop
    append_instr(addi_word(6, 6, -1));
    append_instr(branch_word(f3_bne, 6, 0, -4));
    append_instr(ecall_word());
  endtask

  task automatic branch_test();
    load_branch_program();
    run_program(1'b1);
  endtask

  task automatic jump_test();
    prog_len = 0;
    append_instr(jal_word(1, 12));
    append_instr(addi_word(2, 0, 1));
    append_instr(addi_word(3, 0, 2));
    append_instr(addi_word(4, 1, 0));
    append_instr(jal_word(0, 8));
    append_instr(addi_word(5, 0, 5));
    append_instr(jal_word(0, 12));
    append_instr(addi_word(8, 0, 8));
    append_instr(ecall_word());
    append_instr(jal_word(9, -8));
    run_program(1'b1);
  endtask

  task automatic wait_state_test();
    trace_t fast_trace [$];
    load_branch_program();
    run_program(1'b0);
    fast_trace = got_trace;
    run_program(1'b1);
    check_value("stalled stream length", xlen'(got_trace.size()), xlen'(fast_trace.size()));
    foreach (fast_trace[i]) begin
      if (i < got_trace.size()) begin
        compare_trace("stalled stream", got_trace[i], fast_trace[i]);
      end
    end
  endtask

  initial begin
    reset = 1'b1;
    entry = entry_pc;
    wb_ack = 1'b0;
    wb_dat_i = '0;
    use_waits = 1'b0;
    lfsr_state = 16'd45;
    wait_left = 2'd0;
    req_open = 1'b0;
    prog_len = 0;
    cycle_count = 0;
    check_count = 0;
    error_count = 0;
    register_ops_test();
    immediate_test();
    branch_test();
    jump_test();
    wait_state_test();
    assert_fails = dut0.fetch0.bus_props0.fail_count + dut0.alu0.retire_props0.fail_count;
    $display("checks %0d, errors %0d, assertion failures %0d",
             check_count, error_count, assert_fails);
    if (error_count == 0 && assert_fails == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

//--- compile.f
hdl/riscv_isa_pkg.sv
hdl/core_pkg.sv
hdl/fetch_unit.sv
hdl/register_decode.sv
hdl/alu.sv
hdl/core_top.sv
bench/core_properties.sv
bench/core_tb.sv

//--- hdl/alu.sv
module alu (
  input  logic                               clk,
  input  logic                               reset,
  input  logic                               dec_valid,
  input  core_pkg::alu_op_e                  op,
  input  logic [core_pkg::reg_idx_width-1:0] rd,
  input  logic [core_pkg::xlen-1:0]          a_value,
  input  logic [core_pkg::xlen-1:0]          b_value,
  input  logic [core_pkg::xlen-1:0]          imm,
  input  logic [core_pkg::xlen-1:0]          pc,
  output logic                               wr_en,
  output logic [core_pkg::reg_idx_width-1:0] wr_rd,
  output logic [core_pkg::xlen-1:0]          wr_data,
  output logic                               redirect,
  output logic [core_pkg::xlen-1:0]          redirect_pc,
  output logic                               retire_valid,
  output logic [core_pkg::xlen-1:0]          retire_pc,
  output logic [core_pkg::reg_idx_width-1:0] retire_rd,
  output logic [core_pkg::xlen-1:0]          retire_data,
  output logic                               halted
);
  import core_pkg::*;
  import riscv_isa_pkg::*;

  localparam logic [xlen-1:0] instr_bytes = xlen'(instr_width / 8);

  logic [xlen-1:0] result;
  logic writes_rd;
  logic taken;
  logic lt_signed;

  assign lt_signed = $signed(a_value) < $signed(b_value);

  always_comb begin
    result = '0;
    writes_rd = 1'b1;
    taken = 1'b0;
    case (op)
      alu_add: result = a_value + b_value;
      alu_sub: result = a_value - b_value;
      alu_and: result = a_value & b_value;
      alu_or: result = a_value | b_value;
      alu_xor: result = a_value ^ b_value;
      alu_slt: result = {{(xlen-1){1'b0}}, lt_signed};
      alu_pass_b: result = b_value;
      alu_beq: begin
        writes_rd = 1'b0;
        taken = (a_value == b_value);
      end
      alu_bne: begin
        writes_rd = 1'b0;
        taken = (a_value != b_value);
      end
      alu_jal: begin
        // link address
        result = pc + instr_bytes;
        taken = 1'b1;
      end
      default: writes_rd = 1'b0;
    endcase
  end

  // register file write lands on this cycle's closing edge
  assign wr_en = dec_valid && writes_rd;
  assign wr_rd = rd;
  assign wr_data = result;

  always_ff @(posedge clk) begin
    if (reset) begin
      retire_valid <= 1'b0;
      redirect <= 1'b0;
      halted <= 1'b0;
    end else begin
      retire_valid <= dec_valid;
      redirect <= dec_valid && taken;
      if (dec_valid && (op == alu_ecall)) begin
        halted <= 1'b1;
      end
    end
  end

  // retire trace, branches and ecall report rd 0 and data 0
  always_ff @(posedge clk) begin
    if (dec_valid) begin
      retire_pc <= pc;
      retire_rd <= writes_rd ? rd : '0;
      retire_data <= writes_rd ? result : '0;
      redirect_pc <= pc + imm;
    end
  end

endmodule

//--- hdl/core_pkg.sv
package core_pkg;

  localparam int xlen = 64;
  localparam int reg_count = 32;
  localparam int reg_idx_width = 5;

  // operations carried from decode to execute
  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_and,
    alu_or,
    alu_xor,
    alu_slt,
    alu_pass_b,
    alu_beq,
    alu_bne,
    alu_jal,
    alu_ecall
  } alu_op_e;

  // instruction fetch bus states
  typedef enum logic [1:0] {
    fetch_idle,
    fetch_bus_wait,
    fetch_discard
  } fetch_state_e;

endpackage

//--- hdl/core_top.sv
module core_top #(
  parameter int bus_addr_width = 32
) (
  input  logic                                  clk,
  input  logic                                  reset,
  input  logic [core_pkg::xlen-1:0]             entry,
  input  logic                                  wb_ack,
  input  logic [riscv_isa_pkg::instr_width-1:0] wb_dat_i,
  output logic                                  wb_cyc,
  output logic                                  wb_stb,
  output logic [bus_addr_width-1:0]             wb_adr,
  output logic                                  retire_valid,
  output logic [core_pkg::xlen-1:0]             retire_pc,
  output logic [core_pkg::reg_idx_width-1:0]    retire_rd,
  output logic [core_pkg::xlen-1:0]             retire_data,
  output logic                                  halted
);
  import core_pkg::*;
  import riscv_isa_pkg::*;

  // fetch to decode
  logic instr_valid;
  logic instr_take;
  logic [instr_width-1:0] instr;
  logic [xlen-1:0] instr_pc;

  // decode to execute
  logic dec_valid;
  alu_op_e op;
  logic [reg_idx_width-1:0] rd;
  logic [xlen-1:0] a_value;
  logic [xlen-1:0] b_value;
  logic [xlen-1:0] imm;
  logic [xlen-1:0] pc;

  // execute back to decode and fetch
  logic wr_en;
  logic [reg_idx_width-1:0] wr_rd;
  logic [xlen-1:0] wr_data;
  logic redirect;
  logic [xlen-1:0] redirect_pc;

  fetch_unit #(
    .bus_addr_width(bus_addr_width)
  ) fetch0 (
    .clk(clk),
    .reset(reset),
    .entry(entry),
    .wb_ack(wb_ack),
    .wb_dat_i(wb_dat_i),
    .instr_take(instr_take),
    .redirect(redirect),
    .redirect_pc(redirect_pc),
    .halted(halted),
    .wb_cyc(wb_cyc),
    .wb_stb(wb_stb),
    .wb_adr(wb_adr),
    .instr_valid(instr_valid),
    .instr(instr),
    .instr_pc(instr_pc)
  );

  register_decode decode0 (
    .clk(clk),
    .reset(reset),
    .instr_valid(instr_valid),
    .instr(instr),
    .instr_pc(instr_pc),
    .wr_en(wr_en),
    .wr_rd(wr_rd),
    .wr_data(wr_data),
    .halted(halted),
    .instr_take(instr_take),
    .dec_valid(dec_valid),
    .op(op),
    .rd(rd),
    .a_value(a_value),
    .b_value(b_value),
    .imm(imm),
    .pc(pc)
  );

  alu alu0 (
    .clk(clk),
    .reset(reset),
    .dec_valid(dec_valid),
    .op(op),
    .rd(rd),
    .a_value(a_value),
    .b_value(b_value),
    .imm(imm),
    .pc(pc),
    .wr_en(wr_en),
    .wr_rd(wr_rd),
    .wr_data(wr_data),
    .redirect(redirect),
    .redirect_pc(redirect_pc),
    .retire_valid(retire_valid),
    .retire_pc(retire_pc),
    .retire_rd(retire_rd),
    .retire_data(retire_data),
    .halted(halted)
  );

endmodule

//--- hdl/fetch_unit.sv
module fetch_unit #(
  parameter int bus_addr_width = 32
) (
  input  logic                                  clk,
  input  logic                                  reset,
  input  logic [core_pkg::xlen-1:0]             entry,
  input  logic                                  wb_ack,
  input  logic [riscv_isa_pkg::instr_width-1:0] wb_dat_i,
  input  logic                                  instr_take,
  input  logic                                  redirect,
  input  logic [core_pkg::xlen-1:0]             redirect_pc,
  input  logic                                  halted,
  output logic                                  wb_cyc,
  output logic                                  wb_stb,
  output logic [bus_addr_width-1:0]             wb_adr,
  output logic                                  instr_valid,
  output logic [riscv_isa_pkg::instr_width-1:0] instr,
  output logic [core_pkg::xlen-1:0]             instr_pc
);
  import core_pkg::*;
  import riscv_isa_pkg::*;

  localparam logic [xlen-1:0] instr_bytes = xlen'(instr_width / 8);

  fetch_state_e state;
  // address of the next word to request
  logic [xlen-1:0] fetch_pc;
  logic [xlen-1:0] next_pc;
  // address of the request on the bus
  logic [xlen-1:0] req_pc;
  logic issue;
  logic ack_in_wait;

  logic buf_valid;
  logic [instr_width-1:0] buf_instr;
  logic [xlen-1:0] buf_pc;

  // a redirect takes effect for a request issued in the same cycle
  assign next_pc = redirect ? redirect_pc : fetch_pc;

  // new request only when the buffer is free by the next edge
  assign issue = (state == fetch_idle) && !halted &&
                 (!buf_valid || instr_take || redirect);

  assign ack_in_wait = (state == fetch_bus_wait) && wb_ack;

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= fetch_idle;
      fetch_pc <= entry;
    end else begin
      if (issue) begin
        fetch_pc <= next_pc + instr_bytes;
      end else if (redirect) begin
        fetch_pc <= redirect_pc;
      end
      case (state)
        fetch_idle: begin
          if (issue) begin
            state <= fetch_bus_wait;
          end
        end
        fetch_bus_wait: begin
          if (wb_ack) begin
            state <= fetch_idle;
          end else if (redirect) begin
            // let the open cycle finish, its word is stale
            state <= fetch_discard;
          end
        end
        fetch_discard: begin
          if (wb_ack) begin
            state <= fetch_idle;
          end
        end
        default: state <= fetch_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (issue) begin
      req_pc <= next_pc;
    end
  end

  // one-entry instruction buffer
  always_ff @(posedge clk) begin
    if (reset || redirect) begin
      buf_valid <= 1'b0;
    end else if (ack_in_wait) begin
      buf_valid <= 1'b1;
    end else if (instr_take) begin
      buf_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (ack_in_wait && !redirect) begin
      buf_instr <= wb_dat_i;
      buf_pc <= req_pc;
    end
  end

  assign wb_cyc = (state != fetch_idle);
  assign wb_stb = (state != fetch_idle);
  assign wb_adr = req_pc[bus_addr_width-1:0];

  // the word behind a taken branch is squashed in the redirect cycle
  assign instr_valid = buf_valid && !redirect;
  assign instr = buf_instr;
  assign instr_pc = buf_pc;

endmodule

//--- hdl/register_decode.sv
module register_decode (
  input  logic                                  clk,
  input  logic                                  reset,
  input  logic                                  instr_valid,
  input  logic [riscv_isa_pkg::instr_width-1:0] instr,
  input  logic [core_pkg::xlen-1:0]             instr_pc,
  input  logic                                  wr_en,
  input  logic [core_pkg::reg_idx_width-1:0]    wr_rd,
  input  logic [core_pkg::xlen-1:0]             wr_data,
  input  logic                                  halted,
  output logic                                  instr_take,
  output logic                                  dec_valid,
  output core_pkg::alu_op_e                     op,
  output logic [core_pkg::reg_idx_width-1:0]    rd,
  output logic [core_pkg::xlen-1:0]             a_value,
  output logic [core_pkg::xlen-1:0]             b_value,
  output logic [core_pkg::xlen-1:0]             imm,
  output logic [core_pkg::xlen-1:0]             pc
);
  import core_pkg::*;
  import riscv_isa_pkg::*;

  logic [xlen-1:0] regs [reg_count];

  opcode_e opcode;
  funct3_e funct3;
  logic [funct7_width-1:0] funct7;
  logic [reg_idx_width-1:0] rd_field;
  logic [reg_idx_width-1:0] rs1;
  logic [reg_idx_width-1:0] rs2;
  logic [xlen-1:0] rs1_value;
  logic [xlen-1:0] rs2_value;

  logic [xlen-1:0] imm_i;
  logic [xlen-1:0] imm_u;
  logic [xlen-1:0] imm_b;
  logic [xlen-1:0] imm_j;

  assign opcode = opcode_e'(instr[opcode_lsb +: opcode_width]);
  assign funct3 = funct3_e'(instr[funct3_lsb +: funct3_width]);
  assign funct7 = instr[funct7_lsb +: funct7_width];
  assign rd_field = instr[rd_lsb +: reg_idx_width];
  assign rs1 = instr[rs1_lsb +: reg_idx_width];
  assign rs2 = instr[rs2_lsb +: reg_idx_width];

  // sign-extended immediates for each format
  assign imm_i = {{(xlen-12){instr[31]}}, instr[31:20]};
  assign imm_u = {{(xlen-32){instr[31]}}, instr[31:12], 12'b0};
  assign imm_b = {{(xlen-13){instr[31]}}, instr[31], instr[7], instr[30:25],
                  instr[11:8], 1'b0};
  assign imm_j = {{(xlen-21){instr[31]}}, instr[31], instr[19:12], instr[20],
                  instr[30:21], 1'b0};

  // decode never stalls, so it takes whatever the buffer offers
  assign instr_take = instr_valid && !halted;
  assign dec_valid = instr_take;
  assign pc = instr_pc;

  // write on the edge that ends the execute cycle
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < reg_count; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en && (wr_rd != '0)) begin
      regs[wr_rd] <= wr_data;
    end
  end

  assign rs1_value = regs[rs1];
  assign rs2_value = regs[rs2];
  assign a_value = rs1_value;

  always_comb begin
    op = alu_add;
    rd = rd_field;
    b_value = rs2_value;
    imm = imm_i;
    case (opcode)
      opc_op: begin
        case (funct3)
          f3_add_sub: begin
            if (funct7 == funct7_sub) begin
              op = alu_sub;
            end
          end
          f3_and: op = alu_and;
          f3_or: op = alu_or;
          f3_xor: op = alu_xor;
          f3_slt: op = alu_slt;
          default: rd = '0;
        endcase
      end
      opc_op_imm: begin
        b_value = imm_i;
      end
      opc_lui: begin
        op = alu_pass_b;
        b_value = imm_u;
        imm = imm_u;
      end
      opc_branch: begin
        rd = '0;
        imm = imm_b;
        case (funct3)
          f3_beq: op = alu_beq;
          f3_bne: op = alu_bne;
          default: op = alu_add;
        endcase
      end
      opc_jal: begin
        op = alu_jal;
        imm = imm_j;
      end
      opc_system: begin
        op = alu_ecall;
        rd = '0;
      end
      // unsupported encodings retire as a write to x0
      default: rd = '0;
    endcase
  end

endmodule

//--- hdl/riscv_isa_pkg.sv
package riscv_isa_pkg;

  // every instruction in the supported subset is 32 bits wide
  localparam int instr_width = 32;

  // lsb positions of the instruction fields
  localparam int opcode_lsb = 0;
  localparam int rd_lsb = 7;
  localparam int funct3_lsb = 12;
  localparam int rs1_lsb = 15;
  localparam int rs2_lsb = 20;
  localparam int funct7_lsb = 25;

  localparam int opcode_width = 7;
  localparam int funct3_width = 3;
  localparam int funct7_width = 7;

  // major opcodes of the supported subset
  typedef enum logic [opcode_width-1:0] {
    opc_op     = 7'b0110011,
    opc_op_imm = 7'b0010011,
    opc_lui    = 7'b0110111,
    opc_branch = 7'b1100011,
    opc_jal    = 7'b1101111,
    opc_system = 7'b1110011
  } opcode_e;

  // funct3 codes, shared by the register-register and branch groups
  typedef enum logic [funct3_width-1:0] {
    f3_add_sub = 3'b000,
    f3_bne     = 3'b001,
    f3_slt     = 3'b010,
    f3_xor     = 3'b100,
    f3_or      = 3'b110,
    f3_and     = 3'b111
  } funct3_e;

  // beq carries the same code as add/sub, inside the branch opcode
  localparam funct3_e f3_beq = f3_add_sub;

  // funct7 value that turns ADD into SUB
  localparam logic [funct7_width-1:0] funct7_sub = 7'b0100000;

endpackage
